// File: hdl/dataPathPkg.sv
// shared widths, register count and ALU op codes; codes outside the list give a zero result
package dataPathPkg;

    localparam int wordWidth       = 32;
    localparam int registerCount   = 16;
    localparam int selectWidth     = 4;     // must cover registerCount
    localparam int opWidth         = 5;
    localparam int iterativeCycles = 32;    // one step per operand bit

    typedef logic [wordWidth-1:0] word;
    typedef logic [opWidth-1:0]   aluOp;

    // single-cycle operations
    localparam aluOp opAnd = 5'd1;
    localparam aluOp opOr  = 5'd2;
    localparam aluOp opAdd = 5'd3;
    localparam aluOp opShl = 5'd4;   // A << B[4:0]
    localparam aluOp opSub = 5'd5;   // A - B
    localparam aluOp opShr = 5'd6;   // logical, A >> B[4:0]
    localparam aluOp opRol = 5'd7;

    // iterative operations, signed
    localparam aluOp opMul = 5'd8;   // full 64-bit product in ZHI:ZLO
    localparam aluOp opDiv = 5'd9;   // quotient in ZLO, remainder in ZHI

    // unary, B only
    localparam aluOp opNeg = 5'd10;
    localparam aluOp opNot = 5'd11;

endpackage

// File: hdl/busIf.sv
// shared bus and all bus source values; one-hot source selection is left to the sequencer
interface busIf;
    import dataPathPkg::*;

    word bus;          // the single shared bus, driven only by busMux

    // memory side sources
    word mdrValue;
    word marValue;

    // register bank sources
    word rfValue;      // general register picked by rfSelect
    word pcValue;
    word irValue;
    word hiValue;
    word loValue;

    // ALU sources
    word yValue;
    word zHi;
    word zLo;

    modport memSide (input bus, output mdrValue, output marValue);

    modport aluSide (input bus, output yValue, output zHi, output zLo);

    modport regSide (
        input  bus,
        output rfValue, pcValue, irValue, hiValue, loValue
    );

    modport muxSide (
        output bus,
        input  mdrValue, marValue,
        input  rfValue, pcValue, irValue, hiValue, loValue,
        input  yValue, zHi, zLo
    );

endinterface

// File: hdl/memoryInterface.sv
// MAR and MDR only; the memory itself sits outside and returns data on memDataIn
module memoryInterface (
    input  logic             Clock,
    input  logic             reset,
    input  logic             memRead,      // selects memDataIn over the bus for MDR
    input  logic             mdrIn,
    input  logic             marIn,
    input  dataPathPkg::word memDataIn,
    output dataPathPkg::word memAddress,
    busIf.memSide            link
);
    import dataPathPkg::*;

    word marReg;
    word mdrReg;
    word mdrSource;

    // MDR takes the memory word on a read, otherwise whatever is on the bus
    always_comb begin
        if (memRead) begin
            mdrSource = memDataIn;
        end else begin
            mdrSource = link.bus;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            marReg <= '0;
            mdrReg <= '0;
        end else begin
            if (marIn) begin
                marReg <= link.bus;
            end
            if (mdrIn) begin
                mdrReg <= mdrSource;
            end
        end
    end

    assign memAddress    = marReg;   // address goes straight out to memory
    assign link.marValue = marReg;
    assign link.mdrValue = mdrReg;

endmodule

// File: hdl/arithLogicUnit.sv
// A is Y, B is the bus at start; mul/div take 33 cycles and ignore start while busy
module arithLogicUnit (
    input  logic              Clock,
    input  logic              reset,
    input  logic              yIn,
    input  logic              zIn,
    input  logic              start,        // one-cycle pulse
    input  dataPathPkg::aluOp opSelect,
    output logic              finished,     // one-cycle pulse
    output logic              busy,
    busIf.aluSide             link
);
    import dataPathPkg::*;

    word yReg;
    word zHiReg;
    word zLoReg;

    // iterative engine state
    logic [$clog2(iterativeCycles)-1:0] count;
    logic divMode;
    logic zPending;       // zIn seen at start, load Z on completion
    logic signsDiffer;
    logic divZero;
    word  accReg;         // product high half or partial remainder
    word  lowReg;         // multiplier bits or quotient bits
    word  magReg;         // multiplicand or divisor magnitude
    word  dividendReg;

    word operandB;
    word magA;
    word magB;
    logic isIterative;
    logic lastStep;

    logic [$clog2(wordWidth)-1:0] shiftAmount;
    logic [2*wordWidth-1:0]       rotWide;
    word                          quickResult;

    logic [wordWidth:0]     addSum;
    logic [wordWidth:0]     shifted;
    logic [wordWidth:0]     trial;
    word                    accNext;
    word                    lowNext;
    logic [2*wordWidth-1:0] fixedResult;

    assign operandB    = link.bus;
    assign magA        = yReg[wordWidth-1] ? -yReg : yReg;
    assign magB        = operandB[wordWidth-1] ? -operandB : operandB;
    assign isIterative = (opSelect == opMul) || (opSelect == opDiv);
    assign lastStep    = int'(count) == iterativeCycles - 1;
    assign shiftAmount = operandB[$clog2(wordWidth)-1:0];
    assign rotWide     = {yReg, yReg} << shiftAmount;   // upper half is the rotation

    always_comb begin
        case (opSelect)
            opAnd:   quickResult = yReg & operandB;
            opOr:    quickResult = yReg | operandB;
            opAdd:   quickResult = yReg + operandB;
            opSub:   quickResult = yReg - operandB;
            opShl:   quickResult = yReg << shiftAmount;
            opShr:   quickResult = yReg >> shiftAmount;
            opRol:   quickResult = rotWide[2*wordWidth-1:wordWidth];
            opNeg:   quickResult = -operandB;
            opNot:   quickResult = ~operandB;
            default: quickResult = '0;
        endcase
    end

    // one step of shift-add multiply or restoring divide
    always_comb begin
        addSum  = {1'b0, accReg} + (lowReg[0] ? {1'b0, magReg} : '0);
        shifted = {accReg, lowReg[wordWidth-1]};
        trial   = shifted - {1'b0, magReg};
        if (divMode) begin
            if (trial[wordWidth]) begin   // negative, restore
                accNext = shifted[wordWidth-1:0];
                lowNext = {lowReg[wordWidth-2:0], 1'b0};
            end else begin
                accNext = trial[wordWidth-1:0];
                lowNext = {lowReg[wordWidth-2:0], 1'b1};
            end
        end else begin
            accNext = addSum[wordWidth:1];
            lowNext = {addSum[0], lowReg[wordWidth-1:1]};
        end
    end

    // sign correction applied to the final step
    always_comb begin
        if (!divMode) begin
            fixedResult = signsDiffer ? -{accNext, lowNext} : {accNext, lowNext};
        end else if (divZero) begin
            fixedResult = {dividendReg, {wordWidth{1'b1}}};
        end else begin
            // remainder follows the dividend, quotient truncates toward zero
            fixedResult[2*wordWidth-1:wordWidth] =
                dividendReg[wordWidth-1] ? -accNext : accNext;
            fixedResult[wordWidth-1:0] = signsDiffer ? -lowNext : lowNext;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            yReg        <= '0;
            zHiReg      <= '0;
            zLoReg      <= '0;
            busy        <= 1'b0;
            finished    <= 1'b0;
            count       <= '0;
            divMode     <= 1'b0;
            zPending    <= 1'b0;
            signsDiffer <= 1'b0;
            divZero     <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (yIn) begin
                yReg <= link.bus;
            end
            if (busy) begin
                count <= count + 1'b1;
                if (lastStep) begin
                    busy     <= 1'b0;
                    finished <= 1'b1;
                    if (zPending) begin
                        {zHiReg, zLoReg} <= fixedResult;
                    end
                end
            end else if (start) begin
                if (isIterative) begin
                    busy        <= 1'b1;
                    count       <= '0;
                    divMode     <= opSelect == opDiv;
                    zPending    <= zIn;
                    signsDiffer <= yReg[wordWidth-1] ^ operandB[wordWidth-1];
                    divZero     <= operandB == '0;
                end else begin
                    finished <= 1'b1;   // single-cycle result ready now
                    if (zIn) begin
                        {zHiReg, zLoReg} <= {{wordWidth{1'b0}}, quickResult};
                    end
                end
            end
        end
    end

    // datapath of the engine
    always_ff @(posedge Clock) begin
        if (!busy && start) begin
            accReg      <= '0;
            lowReg      <= magA;
            magReg      <= magB;
            dividendReg <= yReg;
        end else if (busy) begin
            accReg <= accNext;
            lowReg <= lowNext;
        end
    end

    assign link.yValue = yReg;
    assign link.zHi    = zHiReg;
    assign link.zLo    = zLoReg;

endmodule

// File: hdl/registerBank.sv
// sixteen general registers plus PC, IR, HI, LO; R0 is an ordinary register, not tied to zero
module registerBank (
    input  logic                               Clock,
    input  logic                               reset,
    input  logic                               rfIn,
    input  logic                               pcIn,
    input  logic                               irIn,
    input  logic                               hiIn,
    input  logic                               loIn,
    input  logic [dataPathPkg::selectWidth-1:0] rfSelect,  // shared by read and write
    output dataPathPkg::word                   irWord,
    busIf.regSide                              link
);
    import dataPathPkg::*;

    word generalRegs [registerCount];
    word pcReg;
    word irReg;
    word hiReg;
    word loReg;

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < registerCount; i++) begin
                generalRegs[i] <= '0;
            end
            pcReg <= '0;
            irReg <= '0;
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (rfIn) begin
                generalRegs[rfSelect] <= link.bus;
            end
            if (pcIn) begin
                pcReg <= link.bus;   // no increment here
            end
            if (irIn) begin
                irReg <= link.bus;
            end
            if (hiIn) begin
                hiReg <= link.bus;
            end
            if (loIn) begin
                loReg <= link.bus;
            end
        end
    end

    assign link.rfValue = generalRegs[rfSelect];
    assign link.pcValue = pcReg;
    assign link.irValue = irReg;
    assign link.hiValue = hiReg;
    assign link.loValue = loReg;

    // stored only, decoding belongs to a later control unit
    assign irWord = irReg;

endmodule

// File: hdl/busMux.sv
// out enables must be one-hot or all low; two at once OR their sources together
module busMux (
    input logic   rfOut,
    input logic   pcOut,
    input logic   irOut,
    input logic   yOut,
    input logic   zLoOut,
    input logic   zHiOut,
    input logic   marOut,
    input logic   hiOut,
    input logic   loOut,
    input logic   mdrOut,
    busIf.muxSide link
);
    import dataPathPkg::*;

    // and-or select, so nothing enabled leaves the bus at zero
    always_comb begin
        link.bus = ({wordWidth{rfOut}}  & link.rfValue)
                 | ({wordWidth{pcOut}}  & link.pcValue)
                 | ({wordWidth{irOut}}  & link.irValue)
                 | ({wordWidth{yOut}}   & link.yValue)
                 | ({wordWidth{zLoOut}} & link.zLo)
                 | ({wordWidth{zHiOut}} & link.zHi)
                 | ({wordWidth{marOut}} & link.marValue)
                 | ({wordWidth{hiOut}}  & link.hiValue)
                 | ({wordWidth{loOut}}  & link.loValue)
                 | ({wordWidth{mdrOut}} & link.mdrValue);
    end

endmodule

// File: hdl/dataPath.sv
// single-bus datapath; an external sequencer drives all enables and must wait for finished
module dataPath (
    input  logic                                Clock,
    input  logic                                reset,
    // bus source enables
    input  logic                                rfOut,
    input  logic                                pcOut,
    input  logic                                irOut,
    input  logic                                yOut,
    input  logic                                zLoOut,
    input  logic                                zHiOut,
    input  logic                                marOut,
    input  logic                                hiOut,
    input  logic                                loOut,
    input  logic                                mdrOut,
    // load enables
    input  logic                                rfIn,
    input  logic                                pcIn,
    input  logic                                irIn,
    input  logic                                yIn,
    input  logic                                zIn,
    input  logic                                marIn,
    input  logic                                hiIn,
    input  logic                                loIn,
    input  logic                                mdrIn,
    input  logic [dataPathPkg::selectWidth-1:0] rfSelect,
    input  dataPathPkg::aluOp                   opSelect,
    input  logic                                start,
    input  logic                                memRead,
    input  dataPathPkg::word                    memDataIn,
    output logic                                finished,
    output logic                                busy,
    output dataPathPkg::word                    busValue,   // observation of the shared bus
    output dataPathPkg::word                    memAddress,
    output dataPathPkg::word                    irWord
);

    busIf link ();

    memoryInterface memory (
        .Clock      (Clock),
        .reset      (reset),
        .memRead    (memRead),
        .mdrIn      (mdrIn),
        .marIn      (marIn),
        .memDataIn  (memDataIn),
        .memAddress (memAddress),
        .link       (link.memSide)
    );

    arithLogicUnit alu (
        .Clock    (Clock),
        .reset    (reset),
        .yIn      (yIn),
        .zIn      (zIn),
        .start    (start),
        .opSelect (opSelect),
        .finished (finished),
        .busy     (busy),
        .link     (link.aluSide)
    );

    registerBank registers (
        .Clock    (Clock),
        .reset    (reset),
        .rfIn     (rfIn),
        .pcIn     (pcIn),
        .irIn     (irIn),
        .hiIn     (hiIn),
        .loIn     (loIn),
        .rfSelect (rfSelect),
        .irWord   (irWord),
        .link     (link.regSide)
    );

    busMux sourceSelect (
        .rfOut  (rfOut),
        .pcOut  (pcOut),
        .irOut  (irOut),
        .yOut   (yOut),
        .zLoOut (zLoOut),
        .zHiOut (zHiOut),
        .marOut (marOut),
        .hiOut  (hiOut),
        .loOut  (loOut),
        .mdrOut (mdrOut),
        .link   (link.muxSide)
    );

    assign busValue = link.bus;

endmodule

// File: tests/dataPathProperties.sv
// watches the ALU and bus mux through the top-level ports of dataPath; rules hold outside reset
module dataPathProperties (
    input logic       Clock,
    input logic       reset,
    input logic [9:0] outEnables,   // every bus source enable
    input logic       start,
    input logic       finished,
    input logic       busy
);

    int failureCount = 0;   // rule violations seen so far, for the final verdict

    // at most one source on the shared bus
    singleSource: assert property (@(posedge Clock) disable iff (reset)
        $onehot0(outEnables))
        else begin
            failureCount++;
            $error("more than one bus source enabled at once");
        end

    finishedPulse: assert property (@(posedge Clock) disable iff (reset)
        finished |=> !finished)
        else begin
            failureCount++;
            $error("finished stayed high for two cycles");
        end

    // busy only drops when the running operation completes
    startIgnored: assert property (@(posedge Clock) disable iff (reset)
        (start && busy) |=> ($stable(busy) || finished))
        else begin
            failureCount++;
            $error("start during a running operation changed busy");
        end

endmodule

bind dataPath dataPathProperties busAluRules (
    .Clock      (Clock),
    .reset      (reset),
    .outEnables ({rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut}),
    .start      (start),
    .finished   (finished),
    .busy       (busy)
);

// File: tests/dataPathTb.sv
// acts as the sequencer itself; operands come from a fixed-seed LFSR
module dataPathTb;
    import dataPathPkg::*;

    logic Clock;
    logic reset;
    logic rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut;
    logic rfIn, pcIn, irIn, yIn, zIn, marIn, hiIn, loIn, mdrIn;
    logic [selectWidth-1:0] rfSelect;
    aluOp opSelect;
    logic start;
    logic memRead;
    word  memDataIn;
    logic finished;
    logic busy;
    word  busValue;
    word  memAddress;
    word  irWord;

    // expectations posted by the sequence, compared on the next rising edge
    logic busArmed, addressArmed, irArmed, flagArmed;
    word   expectedWord;
    string wordLabel;
    logic  expectedFinished, expectedBusy;

    logic [63:0] lastResult;
    logic [15:0] lfsrState = 16'd53354;
    int singleOps    = 18;
    int iterativeOps = 8;
    int directedOps  = 12;
    int cycleCount   = 0;

    dataPath UUT (
        .Clock (Clock), .reset (reset),
        .rfOut (rfOut), .pcOut (pcOut), .irOut (irOut), .yOut (yOut),
        .zLoOut (zLoOut), .zHiOut (zHiOut), .marOut (marOut),
        .hiOut (hiOut), .loOut (loOut), .mdrOut (mdrOut),
        .rfIn (rfIn), .pcIn (pcIn), .irIn (irIn), .yIn (yIn), .zIn (zIn),
        .marIn (marIn), .hiIn (hiIn), .loIn (loIn), .mdrIn (mdrIn),
        .rfSelect (rfSelect), .opSelect (opSelect), .start (start),
        .memRead (memRead), .memDataIn (memDataIn),
        .finished (finished), .busy (busy), .busValue (busValue),
        .memAddress (memAddress), .irWord (irWord)
    );

    always #50 Clock = ~Clock;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrStep(logic [15:0] state);
        logic feedback;
        feedback = state[0] ^ state[2] ^ state[3] ^ state[5];
        return {feedback, state[15:1]};
    endfunction

    task automatic randomWord(output word value);
        value = '0;
        for (int i = 0; i < wordWidth; i++) begin
            value = {value[wordWidth-2:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    // ZHI:ZLO as the ALU rules define it
    function automatic logic [63:0] expectedResult(aluOp op, word a, word b);
        longint dividend;
        longint divisor;
        longint quotient;
        longint remainder;
        logic [4:0] amount;
        word low;
        amount = b[4:0];
        low = '0;
        dividend = {{wordWidth{a[wordWidth-1]}}, a};
        divisor = {{wordWidth{b[wordWidth-1]}}, b};
        case (op)
            opAnd: low = a & b;
            opOr:  low = a | b;
            opAdd: low = a + b;
            opSub: low = a - b;
            opShl: low = a << amount;
            opShr: low = a >> amount;
            opRol: low = (a << amount) | (a >> (wordWidth - amount));
            opNeg: low = -b;
            opNot: low = ~b;
            opMul: return dividend * divisor;   // full signed product
            opDiv: begin
                if (b == '0) begin
                    return {a, {wordWidth{1'b1}}};
                end
                quotient = dividend / divisor;    // truncates toward zero
                remainder = dividend % divisor;   // sign of the dividend
                return {remainder[wordWidth-1:0], quotient[wordWidth-1:0]};
            end
            default: low = '0;
        endcase
        return {{wordWidth{1'b0}}, low};
    endfunction

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic checkWord(string name, word actual, word expected);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch at time %0t: %s is %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    task automatic checkFlag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch at time %0t: %s is %b, expected %b",
                $time, name, actual, expected));
        end
    endtask

    // comparing process
    always @(posedge Clock) begin
        if (busArmed) checkWord(wordLabel, busValue, expectedWord);
        if (addressArmed) checkWord("memAddress", memAddress, expectedWord);
        if (irArmed) checkWord("irWord", irWord, expectedWord);
        if (flagArmed) begin
            checkFlag("finished", finished, expectedFinished);
            checkFlag("busy", busy, expectedBusy);
        end
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount > (singleOps + iterativeOps + directedOps) * 40 + 200) begin
            abortRun("timeout: the test sequence did not complete within its cycle limit");
        end
    end

    task automatic clearControls;
        {rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut} = '0;
        {rfIn, pcIn, irIn, yIn, zIn, marIn, hiIn, loIn, mdrIn} = '0;
        rfSelect = '0;
        opSelect = '0;
        start = 1'b0;
        memRead = 1'b0;
        memDataIn = '0;
        {busArmed, addressArmed, irArmed, flagArmed} = '0;
    endtask

    task automatic beginCycle;   // falling edge, all controls back to idle
        @(negedge Clock);
        clearControls;
    endtask

    task automatic expectBus(string name, word value);
        busArmed = 1'b1;
        wordLabel = name;
        expectedWord = value;
    endtask

    task automatic markFlags(logic finishedValue, logic busyValue);
        flagArmed = 1'b1;
        expectedFinished = finishedValue;
        expectedBusy = busyValue;
    endtask

    task automatic loadMdr(word value);
        beginCycle;
        memRead = 1'b1;
        mdrIn = 1'b1;
        memDataIn = value;
    endtask

    task automatic writeRegister(int index, word value);
        loadMdr(value);
        beginCycle;
        mdrOut = 1'b1;
        rfIn = 1'b1;
        rfSelect = index[selectWidth-1:0];
    endtask

    task automatic readRegister(int index, word value);
        beginCycle;
        rfOut = 1'b1;
        rfSelect = index[selectWidth-1:0];
        expectBus($sformatf("R%0d", index), value);
    endtask

    task automatic moveToY(int index);
        beginCycle;
        rfOut = 1'b1;
        rfSelect = index[selectWidth-1:0];
        yIn = 1'b1;
    endtask

    // B comes from a general register; finished must land on the exact cycle
    task automatic startAndWait(aluOp op, int bIndex);
        logic iterative;
        int latency;
        iterative = (op == opMul) || (op == opDiv);
        latency = iterative ? iterativeCycles + 1 : 1;
        beginCycle;
        rfOut = 1'b1;
        rfSelect = bIndex[selectWidth-1:0];
        start = 1'b1;
        zIn = 1'b1;
        opSelect = op;
        markFlags(1'b0, 1'b0);
        for (int c = 1; c <= latency; c++) begin
            beginCycle;
            markFlags(c == latency, iterative && c < latency);
            if (iterative && c == 10) begin
                start = 1'b1;      // must be ignored while busy
                zIn = 1'b1;
                opSelect = opAdd;
            end
        end
    endtask

    task automatic readZ(logic [63:0] value);
        beginCycle;
        zLoOut = 1'b1;
        expectBus("ZLO", value[31:0]);
        markFlags(1'b0, 1'b0);
        beginCycle;
        zHiOut = 1'b1;
        expectBus("ZHI", value[63:32]);
    endtask

    task automatic runOperation(aluOp op, word a, word b);
        writeRegister(4, a);
        writeRegister(5, b);
        moveToY(4);
        startAndWait(op, 5);
        lastResult = expectedResult(op, a, b);
        readZ(lastResult);
    endtask

    task automatic checkAfterReset;
        beginCycle;
        expectBus("busValue", '0);   // nothing enabled
        markFlags(1'b0, 1'b0);
        beginCycle;
        addressArmed = 1'b1;
        expectedWord = '0;
        beginCycle;
        irArmed = 1'b1;
        expectedWord = '0;
        readRegister(7, '0);
    endtask

    task automatic checkMemoryPath;
        word value;
        randomWord(value);
        writeRegister(9, value);
        readRegister(9, value);
        beginCycle;
        rfOut = 1'b1;
        rfSelect = 9;
        marIn = 1'b1;
        beginCycle;
        addressArmed = 1'b1;
        expectedWord = value;
    endtask

    task automatic runReferenceSequence;
        writeRegister(2, 32'd2);
        writeRegister(3, 32'd7);
        writeRegister(1, 32'd24);
        loadMdr(32'h20918000);
        beginCycle;
        mdrOut = 1'b1;
        irIn = 1'b1;
        beginCycle;
        irOut = 1'b1;
        expectBus("IR", 32'h20918000);
        irArmed = 1'b1;
        moveToY(2);
        startAndWait(opSub, 3);    // 2 - 7
        beginCycle;
        zLoOut = 1'b1;
        rfIn = 1'b1;
        rfSelect = 1;
        readRegister(1, -32'd5);
    endtask

    task automatic runSingleCycleOps;
        aluOp ops [9];
        word a;
        word b;
        ops = '{opAnd, opOr, opAdd, opSub, opShl, opShr, opRol, opNeg, opNot};
        for (int i = 0; i < singleOps; i++) begin
            randomWord(a);
            randomWord(b);
            runOperation(ops[i % 9], a, b);
        end
    endtask

    task automatic runIterativeOps;
        aluOp op;
        word a;
        word b;
        for (int i = 0; i < iterativeOps; i++) begin
            randomWord(a);
            randomWord(b);
            op = (i % 2 == 0) ? opMul : opDiv;
            if (i == 2) a[31] = 1'b1;
            if (i == 3) b = '0;             // divide by zero
            if (i == 5) begin
                a[31] = 1'b1;
                b[31] = 1'b1;
            end
            if (i == 7) begin
                a[31] = 1'b1;
                b = (b >> 20) | 32'd1;      // small positive divisor
            end
            runOperation(op, a, b);
        end
    endtask

    task automatic checkHiLo;
        beginCycle;
        zHiOut = 1'b1;
        hiIn = 1'b1;
        beginCycle;
        zLoOut = 1'b1;
        loIn = 1'b1;
        beginCycle;
        hiOut = 1'b1;
        expectBus("HI", lastResult[63:32]);
        beginCycle;
        loOut = 1'b1;
        expectBus("LO", lastResult[31:0]);
    endtask

    initial begin
        Clock = 1'b0;
        reset = 1'b1;
        clearControls;
        repeat (4) @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;
        checkAfterReset;
        checkMemoryPath;
        runReferenceSequence;
        runSingleCycleOps;
        runIterativeOps;
        checkHiLo;
        beginCycle;
        beginCycle;                        // let the last check run
        if (UUT.busAluRules.failureCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "bound assertions failed during the run");
        end
    end

endmodule

// File: build.f
hdl/dataPathPkg.sv
hdl/busIf.sv
hdl/memoryInterface.sv
hdl/arithLogicUnit.sv
hdl/registerBank.sv
hdl/busMux.sv
hdl/dataPath.sv
tests/dataPathProperties.sv
tests/dataPathTb.sv
